/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --assert -Wno-fatal -j 0
TOP       := router_arbiter_tb
FILELIST  := router_arbiter.f
OBJ_DIR   := obj_dir

SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell cat $(FILELIST))

.PHONY: all run clean

all: $(SIM_BIN)

# Rebuilt only when a source or the file list changes.
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# A $fatal in the run gives a nonzero exit status.
run: $(SIM_BIN)
	./$(SIM_BIN)

clean:
	rm -rf $(OBJ_DIR)

/* bench/router_arbiter_asserts.sv */
// Concurrent checks for one output arbiter of the router arbitration unit.
// An instance is bound into every rr_processor inside router_arbiter.
// All checks sample on the rising edge. Only the reset check runs while
// rst_n_i is low.

`timescale 1ns/1ns
`default_nettype none

module router_arbiter_asserts (
	input logic                      clk,
	input logic                      rst_n_i,
	input noc_arb_pkg::port_idx_t    port_id_i,
	input noc_arb_pkg::rr_state_t    state_i,
	input noc_arb_pkg::credit_cnt_t  credit_cnt_i,
	input noc_arb_pkg::port_vec_t    grant_i,
	input noc_arb_pkg::arb_out_ctl_t out_ctl_i
);

	import noc_arb_pkg::*;

	grant_onehot: assert property (@(posedge clk) disable iff (!rst_n_i)
		$onehot0(grant_i))
		else $error("Output %0d grants more than one input.", port_id_i);

	no_self_grant: assert property (@(posedge clk) disable iff (!rst_n_i)
		!grant_i[port_id_i])
		else $error("Output %0d granted its own input port.", port_id_i);

	// One packet owns the output for as long as the state stays busy.
	mux_sel_stable: assert property (@(posedge clk) disable iff (!rst_n_i)
		(state_i == RR_BUSY) |=> (state_i != RR_BUSY) || $stable(out_ctl_i.mux_sel))
		else $error("Output %0d changed mux_sel in the middle of a packet.", port_id_i);

	valid_needs_credit: assert property (@(posedge clk) disable iff (!rst_n_i)
		out_ctl_i.valid |-> (credit_cnt_i != '0))
		else $error("Output %0d forwarded a flit with no credit left.", port_id_i);

	credit_in_range: assert property (@(posedge clk) disable iff (!rst_n_i)
		credit_cnt_i <= credit_cnt_t'(BUF_DEPTH))
		else $error("Output %0d holds more credits than downstream slots.", port_id_i);

	quiet_in_reset: assert property (@(posedge clk)
		!rst_n_i |=> !out_ctl_i.valid && (grant_i == '0))
		else $error("Output %0d is active right after a reset edge.", port_id_i);

endmodule

`default_nettype wire

/* bench/router_arbiter_tb.sv */
// Testbench for router_arbiter with counter models of the input buffers and
// of the downstream buffer behind each output.
// The router sits at y 5, x 5. A destination is drawn for a chosen output,
// never the port the packet arrives on.
// Inputs change on the falling edge and outputs are sampled 1 ns later.
// The run stops at the first error.

`timescale 1ns/1ns
`default_nettype none

module router_arbiter_tb;

	import noc_arb_pkg::*;

	localparam yx_coord_t ROUTER_POS     = 8'h55;
	localparam int        RANDOM_CYCLES  = 800;
	localparam int        DIRECTED_LIMIT = 20;
	localparam int        DRAIN_LIMIT    = 2000;
	localparam int        MAX_QUEUED     = 3;

	logic         clk;
	logic         rst_n_i;
	yx_coord_t    router_pos_i;
	arb_in_t      in_i      [NUM_PORTS];
	port_vec_t    credit_i;
	arb_in_ctl_t  in_ctl_o  [NUM_PORTS];
	arb_out_ctl_t out_ctl_o [NUM_PORTS];

	logic [31:0] rng_state;
	yx_coord_t   pkt_q       [NUM_PORTS][$]; // Destinations of packets in each buffer.
	int          flit_idx    [NUM_PORTS];    // Flits of the head packet already read.
	int          hdr_cycle   [NUM_PORTS];    // Cycle in which the header first showed.
	logic        timed       [NUM_PORTS];    // First read is due two cycles in.
	int          credits     [NUM_PORTS];    // Free downstream slots per output.
	int          owner       [NUM_PORTS];    // Input that holds each output or -1 when free.
	int          next_owner  [NUM_PORTS];    // Input due to win after a release or -1.
	logic        inject_on;
	int          cycle;
	int          flits_queued;
	int          flits_read;
	int          waited;

	router_arbiter i_router_arbiter (
		.clk          (clk),
		.rst_n_i      (rst_n_i),
		.router_pos_i (router_pos_i),
		.in_i         (in_i),
		.credit_i     (credit_i),
		.in_ctl_o     (in_ctl_o),
		.out_ctl_o    (out_ctl_o)
	);

	bind rr_processor router_arbiter_asserts i_router_arbiter_asserts (
		.clk          (clk),
		.rst_n_i      (rst_n_i),
		.port_id_i    (PORT_ID),
		.state_i      (state),
		.credit_cnt_i (credit_cnt),
		.grant_i      (grant_o),
		.out_ctl_i    (out_ctl_o)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#20 clk = ~clk;
		end
	end

	function automatic int next_rand(int range);
		rng_state = rng_state * 32'd1664525 + 32'd1013904223;
		return int'(rng_state[31:16]) % range;
	endfunction

	// Expected output of a packet under YX routing.
	function automatic int yx_route(yx_coord_t dest);
		int dy;
		int dx;
		dy = int'(dest[7:4]) - int'(ROUTER_POS[7:4]);
		dx = int'(dest[3:0]) - int'(ROUTER_POS[3:0]);
		if (dy != 0) begin
			return (dy < 0) ? int'(PORT_N) : int'(PORT_S);
		end
		if (dx != 0) begin
			return (dx < 0) ? int'(PORT_W) : int'(PORT_E);
		end
		return int'(PORT_L);
	endfunction

	function automatic yx_coord_t dest_for(int dst_port);
		logic [3:0] y;
		logic [3:0] x;
		y = ROUTER_POS[7:4];
		x = 4'(next_rand(16));
		case (dst_port)
			int'(PORT_N): y = 4'(next_rand(5));      // Rows 0 to 4.
			int'(PORT_S): y = 4'(6 + next_rand(10)); // Rows 6 to 15.
			int'(PORT_W): x = 4'(next_rand(5));
			int'(PORT_E): x = 4'(6 + next_rand(10));
			default:      x = ROUTER_POS[3:0];
		endcase
		return {y, x};
	endfunction

	// First input after the winner in ring order whose header waits for dst_port.
	function automatic int first_waiter_after(int dst_port, int winner);
		int j;
		for (int k = 1; k < NUM_PORTS; k++) begin
			j = (winner + k) % NUM_PORTS;
			if (pkt_q[j].size() != 0 && flit_idx[j] == 0 && !in_ctl_o[j].read &&
					yx_route(pkt_q[j][0]) == dst_port) begin
				return j;
			end
		end
		return -1;
	endfunction

	task automatic push_packet(int src_port, int dst_port);
		pkt_q[src_port].push_back(dest_for(dst_port));
		flits_queued += PKT_FLITS;
	endtask

	task automatic fail_run();
		$display("Simulation FAILED");
		$fatal(1, "Stopped at the first error.");
	endtask

	task automatic check_value(string name, int got, int expected);
		assert (got == expected) else begin
			$display("ERROR at %0t ns: %s expected %0d, got %0d", $time, name, expected, got);
			fail_run();
		end
	endtask

	task automatic check_true(logic cond, string what);
		assert (cond) else begin
			$display("Check failed at %0t ns: %s", $time, what);
			fail_run();
		end
	endtask

	task automatic drive_inputs();
		int dst;
		for (int p = 0; p < NUM_PORTS; p++) begin
			if (inject_on && pkt_q[p].size() < MAX_QUEUED && next_rand(6) == 0) begin
				dst = next_rand(NUM_PORTS - 1);
				if (dst >= p) begin
					dst++; // Skips the port the packet came in on.
				end
				push_packet(p, dst);
			end
			in_i[p].empty = (pkt_q[p].size() == 0);
			if (flit_idx[p] != 0 && next_rand(4) == 0) begin
				in_i[p].empty = 1'b1; // Next body flit has not arrived yet.
			end
			if (pkt_q[p].size() != 0) begin
				in_i[p].dest = pkt_q[p][0];
			end
			if (!in_i[p].empty && flit_idx[p] == 0 && hdr_cycle[p] < 0) begin
				hdr_cycle[p] = cycle;
			end
		end
		for (int o = 0; o < NUM_PORTS; o++) begin
			credit_i[o] = (credits[o] < BUF_DEPTH) && (next_rand(3) != 0);
		end
	endtask

	task automatic check_cycle();
		int hits [NUM_PORTS];
		int m;
		for (int i = 0; i < NUM_PORTS; i++) begin
			hits[i] = 0;
			if (in_ctl_o[i].read) begin
				check_true(!in_i[i].empty, $sformatf("input %0d read while empty", i));
			end
			if (in_ctl_o[i].read || flit_idx[i] != 0) begin
				check_value($sformatf("in_ctl_o[%0d].demux_sel", i),
					int'(in_ctl_o[i].demux_sel), yx_route(pkt_q[i][0]));
			end
			if (in_ctl_o[i].read && flit_idx[i] == 0 && timed[i]) begin
				check_value($sformatf("cycles from header to in_ctl_o[%0d].read", i),
					cycle - hdr_cycle[i], 2);
			end
		end
		for (int o = 0; o < NUM_PORTS; o++) begin
			if (out_ctl_o[o].valid) begin
				m = int'(out_ctl_o[o].mux_sel);
				check_true(m < NUM_PORTS && m != o,
					$sformatf("output %0d selects input %0d", o, m));
				check_value($sformatf("in_ctl_o[%0d].read", m), int'(in_ctl_o[m].read), 1);
				check_true(credits[o] > 0, $sformatf("output %0d sent with no credit", o));
				if (owner[o] < 0) begin
					if (next_owner[o] >= 0) begin
						check_value($sformatf("out_ctl_o[%0d].mux_sel after a release", o),
							m, next_owner[o]);
					end
					owner[o] = m; // First flit of a new packet.
				end
				check_value($sformatf("out_ctl_o[%0d].mux_sel", o), m, owner[o]);
				check_value($sformatf("output taken by input %0d", m), o,
					yx_route(pkt_q[m][0]));
				hits[m]++;
				credits[o]--;
				if (flit_idx[m] == PKT_FLITS - 1) begin
					next_owner[o] = first_waiter_after(o, m); // The tail frees the output.
					owner[o]      = -1;
				end
			end
			if (credit_i[o]) begin
				credits[o]++;
			end
		end
		for (int i = 0; i < NUM_PORTS; i++) begin
			check_value($sformatf("valids selecting input %0d", i), hits[i],
				int'(in_ctl_o[i].read));
			if (in_ctl_o[i].read) begin
				flits_read++;
				flit_idx[i]++;
				if (flit_idx[i] == PKT_FLITS) begin
					void'(pkt_q[i].pop_front());
					flit_idx[i]  = 0;
					hdr_cycle[i] = -1;
					timed[i]     = 1'b0;
				end
			end
		end
	endtask

	task automatic run_cycle();
		@(negedge clk);
		cycle++;
		drive_inputs();
		#1;
		check_cycle();
	endtask

	initial begin
		rng_state    = 32'd75127;
		rst_n_i      = 1'b0;
		router_pos_i = ROUTER_POS;
		credit_i     = '0;
		inject_on    = 1'b0;
		cycle        = 0;
		flits_queued = 0;
		flits_read   = 0;
		// Every input holds a header through reset, each for a different output.
		for (int p = 0; p < NUM_PORTS; p++) begin
			flit_idx[p]   = 0;
			hdr_cycle[p]  = 0;
			timed[p]      = 1'b1;
			credits[p]    = BUF_DEPTH;
			owner[p]      = -1;
			next_owner[p] = -1;
			push_packet(p, (p + 1) % NUM_PORTS);
			in_i[p]       = '{empty: 1'b0, dest: pkt_q[p][0]};
		end
		repeat (10) @(negedge clk);
		rst_n_i = 1'b1;
		#1;
		for (int p = 0; p < NUM_PORTS; p++) begin
			check_value($sformatf("in_ctl_o[%0d].read", p), int'(in_ctl_o[p].read), 0);
			check_value($sformatf("out_ctl_o[%0d].valid", p), int'(out_ctl_o[p].valid), 0);
		end

		waited = 0;
		while (flits_read == 0) begin
			run_cycle();
			waited++;
			if (waited > DIRECTED_LIMIT) begin
				$display("Timeout: no header held through reset was ever read.");
				fail_run();
			end
		end

		inject_on = 1'b1;
		repeat (RANDOM_CYCLES) begin
			run_cycle();
		end
		inject_on = 1'b0;
		waited = 0;
		while (flits_read < flits_queued) begin
			run_cycle();
			waited++;
			if (waited > DRAIN_LIMIT) begin
				$display("Timeout: only %0d of %0d queued flits were delivered.",
					flits_read, flits_queued);
				fail_run();
			end
		end
		$display("Simulation PASSED");
		$finish;
	end

endmodule

`default_nettype wire

/* hw/nexthop_register.sv */
// Next-hop register for one input port, with YX dimension-order routing.
// The route is taken from the head flit while no packet is in progress and
// held until the tail flit is read.
// A packet addressed to this router goes to the local port; the local input
// must never carry such a packet.

`timescale 1ns/1ns
`default_nettype none

module nexthop_register (
	input  logic                  clk,
	input  logic                  rst_n_i,
	input  noc_arb_pkg::arb_in_t   in_i,
	input  noc_arb_pkg::yx_coord_t router_pos_i,
	input  logic                  pt_idle_i,
	input  logic                  tail_read_i,
	input  logic                  read_i,
	output logic                  hop_valid_o,
	output noc_arb_pkg::port_idx_t hop_port_o
);

	import noc_arb_pkg::*;

	port_idx_t route;
	logic      load;

	// Y is resolved first, then x.
	always_comb begin
		if (in_i.dest[7:4] < router_pos_i[7:4]) begin
			route = PORT_N;
		end else if (in_i.dest[7:4] > router_pos_i[7:4]) begin
			route = PORT_S;
		end else if (in_i.dest[3:0] < router_pos_i[3:0]) begin
			route = PORT_W;
		end else if (in_i.dest[3:0] > router_pos_i[3:0]) begin
			route = PORT_E;
		end else begin
			route = PORT_L;
		end
	end

	// The head of the buffer is a header only while the tracker is idle.
	assign load = !in_i.empty && pt_idle_i && !read_i;

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			hop_valid_o <= 1'b0;
			hop_port_o  <= PORT_N;
		end else if (tail_read_i) begin
			hop_valid_o <= 1'b0; // Packet done, the select is left as it was.
		end else if (load) begin
			hop_valid_o <= 1'b1;
			hop_port_o  <= route;
		end
	end

endmodule

`default_nettype wire

/* hw/noc_arb_pkg.sv */
// Shared types and constants for the five-port mesh router arbitration unit.
// Port order is N, S, W, E, L, and every per-port vector uses that order.
// Coordinates hold y in the upper nibble and x in the lower nibble, so the
// mesh is limited to 16 by 16 routers.
// Packets have a fixed length of PKT_FLITS flits.
// BUF_DEPTH must fit in credit_cnt_t.

`default_nettype none

package noc_arb_pkg;

	localparam int NUM_PORTS = 5;

	typedef logic [2:0] port_idx_t; // Port index, 0 to NUM_PORTS-1.

	localparam port_idx_t PORT_N = 3'd0;
	localparam port_idx_t PORT_S = 3'd1;
	localparam port_idx_t PORT_W = 3'd2;
	localparam port_idx_t PORT_E = 3'd3;
	localparam port_idx_t PORT_L = 3'd4;

	typedef logic [NUM_PORTS-1:0] port_vec_t; // One bit per port.

	typedef logic [7:0] yx_coord_t; // Bits 7:4 are y and bits 3:0 are x.

	localparam int PKT_FLITS = 4;
	localparam int BUF_DEPTH = 4; // Downstream slots, also the reset credit.

	typedef logic [2:0] credit_cnt_t; // Holds 0 to BUF_DEPTH.
	typedef logic [1:0] flit_cnt_t;   // Flit index within one packet.

	// What one input buffer presents to the arbiter.
	typedef struct packed {
		logic      empty;
		yx_coord_t dest;
	} arb_in_t;

	// Control driven back to one input buffer and its demultiplexer.
	typedef struct packed {
		logic      read;
		port_idx_t demux_sel;
	} arb_in_ctl_t;

	// Control for one output, towards the crossbar and the downstream link.
	typedef struct packed {
		logic      valid;
		port_idx_t mux_sel;
	} arb_out_ctl_t;

	typedef enum logic {
		RR_IDLE,
		RR_BUSY
	} rr_state_t;

endpackage

`default_nettype wire

/* hw/packet_tracker.sv */
// Counts the flits read from one input buffer.
// Only fixed-length packets of PKT_FLITS flits are supported; the count
// wraps after the tail, so a lost read strobe misaligns every later packet.
// pt_tail_o is a level: the next read in that state takes the tail flit.

`timescale 1ns/1ns
`default_nettype none

module packet_tracker (
	input  logic clk,
	input  logic rst_n_i,
	input  logic pt_inc_i,
	output logic pt_idle_o,
	output logic pt_tail_o
);

	import noc_arb_pkg::*;

	localparam flit_cnt_t LAST_FLIT = flit_cnt_t'(PKT_FLITS - 1);

	flit_cnt_t flit_cnt; // Flits of the current packet already read.

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			flit_cnt <= '0;
		end else if (pt_inc_i) begin
			if (flit_cnt == LAST_FLIT) begin
				flit_cnt <= '0; // Tail read, back to the header.
			end else begin
				flit_cnt <= flit_cnt + 1'b1;
			end
		end
	end

	// No flit of a packet has been taken yet.
	assign pt_idle_o = (flit_cnt == '0);

	// Armed while waiting for the last flit.
	assign pt_tail_o = (flit_cnt == LAST_FLIT);

endmodule

`default_nettype wire

/* hw/router_arbiter.sv */
// Arbitration unit of one five-port mesh router.
// Inputs and outputs are indexed N, S, W, E, L.
// The flit buffers, crossbar and links are outside; this block only drives
// read strobes, demux selects, forward strobes and crossbar selects.
// Read and valid are combinational from the registered grant, the buffer
// empty level and the credit count, and they fire in the same cycle.

`timescale 1ns/1ns
`default_nettype none

module router_arbiter (
	input  logic                     clk,
	input  logic                     rst_n_i,
	input  noc_arb_pkg::yx_coord_t    router_pos_i,
	input  noc_arb_pkg::arb_in_t      in_i [noc_arb_pkg::NUM_PORTS],
	input  noc_arb_pkg::port_vec_t    credit_i,
	output noc_arb_pkg::arb_in_ctl_t  in_ctl_o [noc_arb_pkg::NUM_PORTS],
	output noc_arb_pkg::arb_out_ctl_t out_ctl_o [noc_arb_pkg::NUM_PORTS]
);

	import noc_arb_pkg::*;

	port_vec_t pt_idle;
	port_vec_t pt_tail;
	port_vec_t rd;       // Read strobe per input.
	port_vec_t tail_rd;  // Read that takes a tail flit.
	port_vec_t hop_valid;
	port_vec_t empty;

	port_idx_t    hop_port [NUM_PORTS];
	port_vec_t    req      [NUM_PORTS]; // Request column of each output.
	port_vec_t    grant    [NUM_PORTS]; // Grant vector of each output.
	arb_out_ctl_t out_ctl  [NUM_PORTS];

	// Output o sees input i when the latched hop of i points at o.
	always_comb begin
		for (int o = 0; o < NUM_PORTS; o++) begin
			for (int i = 0; i < NUM_PORTS; i++) begin
				req[o][i] = hop_valid[i] && (hop_port[i] == port_idx_t'(o)) && (i != o);
			end
		end
	end

	// An input is read whenever the output that owns it forwards a flit.
	always_comb begin
		rd = '0;
		for (int i = 0; i < NUM_PORTS; i++) begin
			for (int o = 0; o < NUM_PORTS; o++) begin
				rd[i] = rd[i] | (grant[o][i] & out_ctl[o].valid);
			end
		end
	end

	assign tail_rd = pt_tail & rd;

	for (genvar p = 0; p < NUM_PORTS; p++) begin : g_port
		assign empty[p] = in_i[p].empty;

		packet_tracker i_packet_tracker (
			.clk       (clk),
			.rst_n_i   (rst_n_i),
			.pt_inc_i  (rd[p]),
			.pt_idle_o (pt_idle[p]),
			.pt_tail_o (pt_tail[p])
		);

		nexthop_register i_nexthop_register (
			.clk          (clk),
			.rst_n_i      (rst_n_i),
			.in_i         (in_i[p]),
			.router_pos_i (router_pos_i),
			.pt_idle_i    (pt_idle[p]),
			.tail_read_i  (tail_rd[p]),
			.read_i       (rd[p]),
			.hop_valid_o  (hop_valid[p]),
			.hop_port_o   (hop_port[p])
		);

		rr_processor #(
			.PORT_ID (port_idx_t'(p))
		) i_rr_processor (
			.clk       (clk),
			.rst_n_i   (rst_n_i),
			.req_i     (req[p]),
			.tail_i    (tail_rd),
			.empty_i   (empty),
			.credit_i  (credit_i[p]),
			.grant_o   (grant[p]),
			.out_ctl_o (out_ctl[p])
		);

		assign in_ctl_o[p].read      = rd[p];
		assign in_ctl_o[p].demux_sel = hop_port[p]; // Steers the flit to its output.
		assign out_ctl_o[p]          = out_ctl[p];
	end

endmodule

`default_nettype wire

/* hw/rr_processor.sv */
// Round-robin arbiter for one output port.
// A grant is registered from RR_IDLE and held for the whole packet, so the
// first flit goes out one cycle after the request is seen.
// Each valid spends one downstream credit and each credit_i pulse returns
// one; credit_i must never push the count above BUF_DEPTH.
// The output never grants its own input port.

`timescale 1ns/1ns
`default_nettype none

module rr_processor #(
	parameter noc_arb_pkg::port_idx_t PORT_ID = noc_arb_pkg::PORT_N
) (
	input  logic                     clk,
	input  logic                     rst_n_i,
	input  noc_arb_pkg::port_vec_t    req_i,
	input  noc_arb_pkg::port_vec_t    tail_i,
	input  noc_arb_pkg::port_vec_t    empty_i,
	input  logic                     credit_i,
	output noc_arb_pkg::port_vec_t    grant_o,
	output noc_arb_pkg::arb_out_ctl_t out_ctl_o
);

	import noc_arb_pkg::*;

	rr_state_t   state;
	port_idx_t   rr_ptr;     // First input looked at in the next search.
	port_idx_t   gnt_idx;    // Input that currently owns this output.
	credit_cnt_t credit_cnt; // Free slots in the downstream buffer.

	port_idx_t pick_idx;
	logic      pick_found;
	logic      fwd;

	// Modulo NUM_PORTS step around the ring of ports.
	function automatic port_idx_t ring_add(port_idx_t base, int unsigned step);
		int unsigned sum;
		sum = int'(base) + step;
		if (sum >= NUM_PORTS) begin
			sum = sum - NUM_PORTS;
		end
		return port_idx_t'(sum);
	endfunction

	// First requester at or after the pointer, skipping this output's own port.
	always_comb begin
		port_idx_t cand;
		pick_found = 1'b0;
		pick_idx   = rr_ptr;
		for (int k = 0; k < NUM_PORTS; k++) begin
			cand = ring_add(rr_ptr, k);
			if (!pick_found && cand != PORT_ID && req_i[cand]) begin
				pick_found = 1'b1;
				pick_idx   = cand;
			end
		end
	end

	// Forward when the owner has a flit and there is room downstream.
	assign fwd = (state == RR_BUSY) && !empty_i[gnt_idx] && (credit_cnt != '0);

	always_comb begin
		grant_o = '0;
		if (state == RR_BUSY) begin
			grant_o[gnt_idx] = 1'b1;
		end
	end

	assign out_ctl_o.valid   = fwd;
	assign out_ctl_o.mux_sel = gnt_idx;

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			state      <= RR_IDLE;
			rr_ptr     <= PORT_N;
			gnt_idx    <= PORT_N;
			credit_cnt <= credit_cnt_t'(BUF_DEPTH);
		end else begin
			if (fwd && !credit_i) begin
				credit_cnt <= credit_cnt - 1'b1;
			end else if (!fwd && credit_i) begin
				credit_cnt <= credit_cnt + 1'b1;
			end

			case (state)
				RR_IDLE: begin
					if (pick_found) begin
						gnt_idx <= pick_idx;
						state   <= RR_BUSY;
					end
				end
				RR_BUSY: begin
					if (fwd && tail_i[gnt_idx]) begin
						state  <= RR_IDLE; // Tail has left, release the output.
						rr_ptr <= ring_add(gnt_idx, 1);
					end
				end
				default: state <= RR_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

/* router_arbiter.f */
hw/noc_arb_pkg.sv
hw/packet_tracker.sv
hw/nexthop_register.sv
hw/rr_processor.sv
hw/router_arbiter.sv
bench/router_arbiter_asserts.sv
bench/router_arbiter_tb.sv
